// File: verilog/axil_defs.svh
`ifndef AXIL_DEFS_SVH
`define AXIL_DEFS_SVH

// Bus widths
`define AXIL_ADDR_W 32
`define AXIL_DATA_W 32
`define AXIL_STRB_W 4

// Upstream managers sharing the downstream bus
`define AXIL_N_PORTS 4

// Outstanding transactions per path and index FIFO depth
`define AXIL_MAX_TRANS 4

`endif

// File: verilog/axil_pkg.sv
`default_nettype none

`include "axil_defs.svh"

package axil_pkg;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axil_resp_e;

  typedef struct packed {
    logic [`AXIL_ADDR_W-1:0] addr;
    logic [2:0]              prot;
  } aw_chan_t;

  typedef struct packed {
    logic [`AXIL_ADDR_W-1:0] addr;
    logic [2:0]              prot;
  } ar_chan_t;

  typedef struct packed {
    logic [`AXIL_DATA_W-1:0] data;
    logic [`AXIL_STRB_W-1:0] strb;
  } w_chan_t;

  typedef struct packed {
    axil_resp_e resp;
  } b_chan_t;

  typedef struct packed {
    logic [`AXIL_DATA_W-1:0] data;
    axil_resp_e              resp;
  } r_chan_t;

  typedef logic [$clog2(`AXIL_N_PORTS)-1:0] port_idx_t;

endpackage

`default_nettype wire

// File: verilog/axil_bus_if.sv
`default_nettype none

// Downstream write channels AW, W and B
interface axil_wr_if;
  axil_pkg::aw_chan_t aw;
  logic               aw_valid;
  logic               aw_ready;
  axil_pkg::w_chan_t  w;
  logic               w_valid;
  logic               w_ready;
  axil_pkg::b_chan_t  b;
  logic               b_valid;
  logic               b_ready;

  modport mgr (
    output aw, aw_valid, w, w_valid, b_ready,
    input  aw_ready, w_ready, b, b_valid
  );

  modport sub (
    input  aw, aw_valid, w, w_valid, b_ready,
    output aw_ready, w_ready, b, b_valid
  );
endinterface

// Downstream read channels AR and R
interface axil_rd_if;
  axil_pkg::ar_chan_t ar;
  logic               ar_valid;
  logic               ar_ready;
  axil_pkg::r_chan_t  r;
  logic               r_valid;
  logic               r_ready;

  modport mgr (output ar, ar_valid, r_ready, input ar_ready, r, r_valid);
  modport sub (input ar, ar_valid, r_ready, output ar_ready, r, r_valid);
endinterface

`default_nettype wire

// File: verilog/axil_rr_arbiter.sv
`default_nettype none

`include "axil_defs.svh"

module axil_rr_arbiter (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic [`AXIL_N_PORTS-1:0] req_i,
  input  logic                     release_i,
  output logic                     gnt_valid_o,
  output axil_pkg::port_idx_t      gnt_idx_o
);

  typedef enum logic {IDLE, LOCKED} arb_state_e;

  arb_state_e          state_q;
  axil_pkg::port_idx_t ptr_q;      // Highest priority port
  axil_pkg::port_idx_t lock_idx_q;
  axil_pkg::port_idx_t pick_idx;
  logic                pick_found;

  // First requester at or after the pointer
  always_comb begin
    axil_pkg::port_idx_t cand;
    pick_found = 1'b0;
    pick_idx   = ptr_q;
    for (int i = 0; i < `AXIL_N_PORTS; i++) begin
      cand = axil_pkg::port_idx_t'((int'(ptr_q) + i) % `AXIL_N_PORTS);
      if (!pick_found && req_i[cand]) begin
        pick_found = 1'b1;
        pick_idx   = cand;
      end
    end
  end

  assign gnt_valid_o = (state_q == LOCKED) || pick_found;
  assign gnt_idx_o   = (state_q == LOCKED) ? lock_idx_q : pick_idx;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= IDLE;
      ptr_q      <= '0;
      lock_idx_q <= '0;
    end else if (gnt_valid_o && release_i) begin
      state_q <= IDLE;
      ptr_q   <= (gnt_idx_o == `AXIL_N_PORTS - 1) ? '0 :
                 axil_pkg::port_idx_t'(gnt_idx_o + 1'b1);
    end else if (state_q == IDLE && pick_found) begin
      state_q    <= LOCKED;  // Hold until released
      lock_idx_q <= pick_idx;
    end
  end

endmodule

`default_nettype wire

// File: verilog/axil_index_fifo.sv
`default_nettype none

`include "axil_defs.svh"

module axil_index_fifo (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                push_i,
  input  axil_pkg::port_idx_t push_idx_i,
  input  logic                pop_i,
  output logic                full_o,
  output logic                empty_o,
  output axil_pkg::port_idx_t head_idx_o
);

  localparam int unsigned DEPTH = `AXIL_MAX_TRANS;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  axil_pkg::port_idx_t        mem_q [DEPTH];
  logic [PTR_W-1:0]           wr_ptr_q;
  logic [PTR_W-1:0]           rd_ptr_q;
  logic [$clog2(DEPTH+1)-1:0] count_q;
  logic                       push_en;
  logic                       pop_en;

  assign full_o     = (count_q == DEPTH);
  assign empty_o    = (count_q == 0);
  assign head_idx_o = mem_q[rd_ptr_q];  // Valid while not empty

  assign push_en = push_i && !full_o;
  assign pop_en  = pop_i && !empty_o;

  always_ff @(posedge clk_i) begin
    if (push_en) mem_q[wr_ptr_q] <= push_idx_i;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_en) wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop_en) rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      case ({push_en, pop_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verilog/axil_write_mux.sv
`default_nettype none

`include "axil_defs.svh"

module axil_write_mux (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  axil_pkg::aw_chan_t [`AXIL_N_PORTS-1:0] up_aw_i,
  input  logic               [`AXIL_N_PORTS-1:0] up_aw_valid_i,
  output logic               [`AXIL_N_PORTS-1:0] up_aw_ready_o,
  input  axil_pkg::w_chan_t  [`AXIL_N_PORTS-1:0] up_w_i,
  input  logic               [`AXIL_N_PORTS-1:0] up_w_valid_i,
  output logic               [`AXIL_N_PORTS-1:0] up_w_ready_o,
  output axil_pkg::b_chan_t  [`AXIL_N_PORTS-1:0] up_b_o,
  output logic               [`AXIL_N_PORTS-1:0] up_b_valid_o,
  input  logic               [`AXIL_N_PORTS-1:0] up_b_ready_i,
  axil_wr_if.mgr                                 bus
);

  logic [`AXIL_N_PORTS-1:0] req;
  logic                     gnt_valid;
  axil_pkg::port_idx_t      gnt_idx;
  logic                     aw_done_q;
  logic                     w_done_q;
  logic                     aw_fire;
  logic                     w_fire;
  logic                     wr_release;
  logic                     fifo_full;
  logic                     fifo_empty;
  axil_pkg::port_idx_t      head_idx;

  // A port competes only with both AW and W present
  assign req = up_aw_valid_i & up_w_valid_i & {`AXIL_N_PORTS{!fifo_full}};

  axil_rr_arbiter u_arb (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (req),
    .release_i   (wr_release),
    .gnt_valid_o (gnt_valid),
    .gnt_idx_o   (gnt_idx)
  );

  assign bus.aw       = up_aw_i[gnt_idx];
  assign bus.aw_valid = gnt_valid && !aw_done_q;
  assign bus.w        = up_w_i[gnt_idx];
  assign bus.w_valid  = gnt_valid && !w_done_q;

  assign aw_fire    = bus.aw_valid && bus.aw_ready;
  assign w_fire     = bus.w_valid && bus.w_ready;
  assign wr_release = gnt_valid && (aw_done_q || aw_fire) && (w_done_q || w_fire);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || wr_release) begin
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end else begin
      if (aw_fire) aw_done_q <= 1'b1;
      if (w_fire) w_done_q <= 1'b1;
    end
  end

  axil_index_fifo u_idx_fifo (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .push_i     (wr_release),
    .push_idx_i (gnt_idx),
    .pop_i      (bus.b_valid && bus.b_ready),
    .full_o     (fifo_full),
    .empty_o    (fifo_empty),
    .head_idx_o (head_idx)
  );

  // B goes back to the oldest outstanding writer
  assign bus.b_ready = !fifo_empty && up_b_ready_i[head_idx];

  always_comb begin
    up_aw_ready_o          = '0;
    up_w_ready_o           = '0;
    up_b_valid_o           = '0;
    up_aw_ready_o[gnt_idx] = aw_fire;
    up_w_ready_o[gnt_idx]  = w_fire;
    up_b_valid_o[head_idx] = bus.b_valid && !fifo_empty;
    for (int i = 0; i < `AXIL_N_PORTS; i++) up_b_o[i] = bus.b;
  end

endmodule

`default_nettype wire

// File: verilog/axil_read_mux.sv
`default_nettype none

`include "axil_defs.svh"

module axil_read_mux (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  axil_pkg::ar_chan_t [`AXIL_N_PORTS-1:0] up_ar_i,
  input  logic               [`AXIL_N_PORTS-1:0] up_ar_valid_i,
  output logic               [`AXIL_N_PORTS-1:0] up_ar_ready_o,
  output axil_pkg::r_chan_t  [`AXIL_N_PORTS-1:0] up_r_o,
  output logic               [`AXIL_N_PORTS-1:0] up_r_valid_o,
  input  logic               [`AXIL_N_PORTS-1:0] up_r_ready_i,
  axil_rd_if.mgr                                 bus
);

  logic                gnt_valid;
  axil_pkg::port_idx_t gnt_idx;
  logic                ar_fire;
  logic                fifo_full;
  logic                fifo_empty;
  axil_pkg::port_idx_t head_idx;

  axil_rr_arbiter u_arb (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (up_ar_valid_i & {`AXIL_N_PORTS{!fifo_full}}),
    .release_i   (ar_fire),
    .gnt_valid_o (gnt_valid),
    .gnt_idx_o   (gnt_idx)
  );

  assign bus.ar       = up_ar_i[gnt_idx];
  assign bus.ar_valid = gnt_valid;
  assign ar_fire      = bus.ar_valid && bus.ar_ready;  // Also ends the grant

  axil_index_fifo u_idx_fifo (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .push_i     (ar_fire),
    .push_idx_i (gnt_idx),
    .pop_i      (bus.r_valid && bus.r_ready),
    .full_o     (fifo_full),
    .empty_o    (fifo_empty),
    .head_idx_o (head_idx)
  );

  assign bus.r_ready = !fifo_empty && up_r_ready_i[head_idx];

  always_comb begin
    up_ar_ready_o          = '0;
    up_r_valid_o           = '0;
    up_ar_ready_o[gnt_idx] = ar_fire;
    up_r_valid_o[head_idx] = bus.r_valid && !fifo_empty;
    for (int i = 0; i < `AXIL_N_PORTS; i++) up_r_o[i] = bus.r;
  end

endmodule

`default_nettype wire

// File: verilog/axil_mux.sv
`default_nettype none

`include "axil_defs.svh"

module axil_mux (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  // Upstream managers
  input  axil_pkg::aw_chan_t [`AXIL_N_PORTS-1:0] up_aw_i,
  input  logic               [`AXIL_N_PORTS-1:0] up_aw_valid_i,
  output logic               [`AXIL_N_PORTS-1:0] up_aw_ready_o,
  input  axil_pkg::w_chan_t  [`AXIL_N_PORTS-1:0] up_w_i,
  input  logic               [`AXIL_N_PORTS-1:0] up_w_valid_i,
  output logic               [`AXIL_N_PORTS-1:0] up_w_ready_o,
  output axil_pkg::b_chan_t  [`AXIL_N_PORTS-1:0] up_b_o,
  output logic               [`AXIL_N_PORTS-1:0] up_b_valid_o,
  input  logic               [`AXIL_N_PORTS-1:0] up_b_ready_i,
  input  axil_pkg::ar_chan_t [`AXIL_N_PORTS-1:0] up_ar_i,
  input  logic               [`AXIL_N_PORTS-1:0] up_ar_valid_i,
  output logic               [`AXIL_N_PORTS-1:0] up_ar_ready_o,
  output axil_pkg::r_chan_t  [`AXIL_N_PORTS-1:0] up_r_o,
  output logic               [`AXIL_N_PORTS-1:0] up_r_valid_o,
  input  logic               [`AXIL_N_PORTS-1:0] up_r_ready_i,
  // Shared downstream bus
  output axil_pkg::aw_chan_t                     mst_aw_o,
  output logic                                   mst_aw_valid_o,
  input  logic                                   mst_aw_ready_i,
  output axil_pkg::w_chan_t                      mst_w_o,
  output logic                                   mst_w_valid_o,
  input  logic                                   mst_w_ready_i,
  input  axil_pkg::b_chan_t                      mst_b_i,
  input  logic                                   mst_b_valid_i,
  output logic                                   mst_b_ready_o,
  output axil_pkg::ar_chan_t                     mst_ar_o,
  output logic                                   mst_ar_valid_o,
  input  logic                                   mst_ar_ready_i,
  input  axil_pkg::r_chan_t                      mst_r_i,
  input  logic                                   mst_r_valid_i,
  output logic                                   mst_r_ready_o
);

  axil_wr_if wr_bus ();
  axil_rd_if rd_bus ();

  axil_write_mux u_write_mux (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .up_aw_i       (up_aw_i),
    .up_aw_valid_i (up_aw_valid_i),
    .up_aw_ready_o (up_aw_ready_o),
    .up_w_i        (up_w_i),
    .up_w_valid_i  (up_w_valid_i),
    .up_w_ready_o  (up_w_ready_o),
    .up_b_o        (up_b_o),
    .up_b_valid_o  (up_b_valid_o),
    .up_b_ready_i  (up_b_ready_i),
    .bus           (wr_bus)
  );

  axil_read_mux u_read_mux (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .up_ar_i       (up_ar_i),
    .up_ar_valid_i (up_ar_valid_i),
    .up_ar_ready_o (up_ar_ready_o),
    .up_r_o        (up_r_o),
    .up_r_valid_o  (up_r_valid_o),
    .up_r_ready_i  (up_r_ready_i),
    .bus           (rd_bus)
  );

  // Write channels to the pins
  assign mst_aw_o        = wr_bus.aw;
  assign mst_aw_valid_o  = wr_bus.aw_valid;
  assign wr_bus.aw_ready = mst_aw_ready_i;
  assign mst_w_o         = wr_bus.w;
  assign mst_w_valid_o   = wr_bus.w_valid;
  assign wr_bus.w_ready  = mst_w_ready_i;
  assign wr_bus.b        = mst_b_i;
  assign wr_bus.b_valid  = mst_b_valid_i;
  assign mst_b_ready_o   = wr_bus.b_ready;

  assign mst_ar_o        = rd_bus.ar;
  assign mst_ar_valid_o  = rd_bus.ar_valid;
  assign rd_bus.ar_ready = mst_ar_ready_i;
  assign rd_bus.r        = mst_r_i;
  assign rd_bus.r_valid  = mst_r_valid_i;
  assign mst_r_ready_o   = rd_bus.r_ready;

endmodule

`default_nettype wire

// File: test/axil_mem_model.sv
`default_nettype none

`include "axil_defs.svh"

module axil_mem_model (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  axil_pkg::aw_chan_t aw_i,
  input  logic               aw_valid_i,
  output logic               aw_ready_o,
  input  axil_pkg::w_chan_t  w_i,
  input  logic               w_valid_i,
  output logic               w_ready_o,
  output axil_pkg::b_chan_t  b_o,
  output logic               b_valid_o,
  input  logic               b_ready_i,
  input  axil_pkg::ar_chan_t ar_i,
  input  logic               ar_valid_i,
  output logic               ar_ready_o,
  output axil_pkg::r_chan_t  r_o,
  output logic               r_valid_o,
  input  logic               r_ready_i
);

  logic [`AXIL_DATA_W-1:0] mem_q [16];
  integer                  seed = 32'hcf8c;
  logic [31:0]             rnd;
  axil_pkg::aw_chan_t      aw_q;
  axil_pkg::w_chan_t       w_q;
  axil_pkg::ar_chan_t      ar_q;
  logic                    aw_have_q;
  logic                    w_have_q;
  logic                    ar_have_q;
  logic                    aw_rdy_q;
  logic                    w_rdy_q;
  logic                    ar_rdy_q;

  // One request of each kind held at a time
  assign aw_ready_o = aw_rdy_q && !aw_have_q;
  assign w_ready_o  = w_rdy_q && !w_have_q;
  assign ar_ready_o = ar_rdy_q && !ar_have_q;

  always @(posedge clk_i) begin
    rnd = $random(seed);
    if (!rst_n_i) begin
      for (int i = 0; i < 16; i++) mem_q[i] <= 32'h5a5a_0000 ^ (32'(i) * 32'h0101_0101);
      aw_have_q <= 1'b0;
      w_have_q  <= 1'b0;
      ar_have_q <= 1'b0;
      aw_rdy_q  <= 1'b0;
      w_rdy_q   <= 1'b0;
      ar_rdy_q  <= 1'b0;
      b_valid_o <= 1'b0;
      r_valid_o <= 1'b0;
      b_o       <= '0;
      r_o       <= '0;
    end else begin
      aw_rdy_q <= rnd[0];  // Random stalls
      w_rdy_q  <= rnd[1];
      ar_rdy_q <= rnd[2];
      if (aw_valid_i && aw_ready_o) begin
        aw_q      <= aw_i;
        aw_have_q <= 1'b1;
      end
      if (w_valid_i && w_ready_o) begin
        w_q      <= w_i;
        w_have_q <= 1'b1;
      end
      if (b_valid_o && b_ready_i) b_valid_o <= 1'b0;
      // Write completes some cycles after both halves arrive
      if (aw_have_q && w_have_q && !b_valid_o && rnd[3]) begin
        aw_have_q <= 1'b0;
        w_have_q  <= 1'b0;
        b_valid_o <= 1'b1;
        if (aw_q.addr >= 32'h40) begin
          b_o.resp <= axil_pkg::DECERR;
        end else begin
          b_o.resp <= axil_pkg::OKAY;
          for (int b = 0; b < 4; b++)
            if (w_q.strb[b]) mem_q[aw_q.addr[5:2]][8*b +: 8] <= w_q.data[8*b +: 8];
        end
      end
      if (ar_valid_i && ar_ready_o) begin
        ar_q      <= ar_i;
        ar_have_q <= 1'b1;
      end
      if (r_valid_o && r_ready_i) r_valid_o <= 1'b0;
      if (ar_have_q && !r_valid_o && rnd[4]) begin
        ar_have_q <= 1'b0;
        r_valid_o <= 1'b1;
        if (ar_q.addr >= 32'h40) begin
          r_o.data <= '0;  // No data outside the window
          r_o.resp <= axil_pkg::DECERR;
        end else begin
          r_o.data <= mem_q[ar_q.addr[5:2]];
          r_o.resp <= axil_pkg::OKAY;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: test/tb_axil_mux.sv
`default_nettype none

`include "axil_defs.svh"

module tb_axil_mux;

  localparam int N              = `AXIL_N_PORTS;
  localparam int N_TESTS        = 16;
  localparam int TIMEOUT_CYCLES = N_TESTS * 64 + 8;

  logic                       clk = 1'b0;
  logic                       rst_n;
  axil_pkg::aw_chan_t [N-1:0] up_aw;
  logic [N-1:0]               up_aw_valid;
  logic [N-1:0]               up_aw_ready;
  axil_pkg::w_chan_t [N-1:0]  up_w;
  logic [N-1:0]               up_w_valid;
  logic [N-1:0]               up_w_ready;
  axil_pkg::b_chan_t [N-1:0]  up_b;
  logic [N-1:0]               up_b_valid;
  logic [N-1:0]               up_b_ready;
  axil_pkg::ar_chan_t [N-1:0] up_ar;
  logic [N-1:0]               up_ar_valid;
  logic [N-1:0]               up_ar_ready;
  axil_pkg::r_chan_t [N-1:0]  up_r;
  logic [N-1:0]               up_r_valid;
  logic [N-1:0]               up_r_ready;
  axil_pkg::aw_chan_t         mst_aw;
  logic                       mst_aw_valid;
  logic                       mst_aw_ready;
  axil_pkg::w_chan_t          mst_w;
  logic                       mst_w_valid;
  logic                       mst_w_ready;
  axil_pkg::b_chan_t          mst_b;
  logic                       mst_b_valid;
  logic                       mst_b_ready;
  axil_pkg::ar_chan_t         mst_ar;
  logic                       mst_ar_valid;
  logic                       mst_ar_ready;
  axil_pkg::r_chan_t          mst_r;
  logic                       mst_r_valid;
  logic                       mst_r_ready;

  // Test table with expected columns filled by derive_expected
  string                   t_name [N_TESTS];
  int                      t_port [N_TESTS];
  bit                      t_all [N_TESTS];  // All ports at once
  bit                      t_wr [N_TESTS];
  logic [`AXIL_ADDR_W-1:0] t_addr [N_TESTS];
  logic [`AXIL_DATA_W-1:0] t_data [N_TESTS];
  logic [`AXIL_STRB_W-1:0] t_strb [N_TESTS];
  axil_pkg::axil_resp_e    t_exp_b [N_TESTS][N];
  axil_pkg::r_chan_t       t_exp_r [N_TESTS][N];
  int                      n_tests = 0;
  int                      cycle_cnt = 0;

  axil_mux u_dut (
    .clk_i (clk), .rst_n_i (rst_n),
    .up_aw_i (up_aw), .up_aw_valid_i (up_aw_valid), .up_aw_ready_o (up_aw_ready),
    .up_w_i (up_w), .up_w_valid_i (up_w_valid), .up_w_ready_o (up_w_ready),
    .up_b_o (up_b), .up_b_valid_o (up_b_valid), .up_b_ready_i (up_b_ready),
    .up_ar_i (up_ar), .up_ar_valid_i (up_ar_valid), .up_ar_ready_o (up_ar_ready),
    .up_r_o (up_r), .up_r_valid_o (up_r_valid), .up_r_ready_i (up_r_ready),
    .mst_aw_o (mst_aw), .mst_aw_valid_o (mst_aw_valid), .mst_aw_ready_i (mst_aw_ready),
    .mst_w_o (mst_w), .mst_w_valid_o (mst_w_valid), .mst_w_ready_i (mst_w_ready),
    .mst_b_i (mst_b), .mst_b_valid_i (mst_b_valid), .mst_b_ready_o (mst_b_ready),
    .mst_ar_o (mst_ar), .mst_ar_valid_o (mst_ar_valid), .mst_ar_ready_i (mst_ar_ready),
    .mst_r_i (mst_r), .mst_r_valid_i (mst_r_valid), .mst_r_ready_o (mst_r_ready)
  );

  axil_mem_model u_mem (
    .clk_i (clk), .rst_n_i (rst_n),
    .aw_i (mst_aw), .aw_valid_i (mst_aw_valid), .aw_ready_o (mst_aw_ready),
    .w_i (mst_w), .w_valid_i (mst_w_valid), .w_ready_o (mst_w_ready),
    .b_o (mst_b), .b_valid_o (mst_b_valid), .b_ready_i (mst_b_ready),
    .ar_i (mst_ar), .ar_valid_i (mst_ar_valid), .ar_ready_o (mst_ar_ready),
    .r_o (mst_r), .r_valid_o (mst_r_valid), .r_ready_i (mst_r_ready)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > TIMEOUT_CYCLES) stop_run("Timeout, transactions did not complete");
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic check_resp(input string name, input axil_pkg::axil_resp_e exp_resp,
                            input axil_pkg::axil_resp_e act_resp);
    if (act_resp !== exp_resp)
      stop_run($sformatf("MISMATCH %s: expected %s, actual %s (%b)", name,
                         exp_resp.name(), act_resp.name(), act_resp));
  endtask

  task automatic check_rdata(input string name, input axil_pkg::r_chan_t exp_r,
                             input axil_pkg::r_chan_t act_r);
    if (act_r !== exp_r)
      stop_run($sformatf("MISMATCH %s: expected %h, actual %h", name, exp_r, act_r));
  endtask

  task automatic add_test(input string name, input int port, input bit all, input bit wr,
                          input logic [31:0] addr, input logic [31:0] data,
                          input logic [3:0] strb);
    t_name[n_tests] = name;
    t_port[n_tests] = port;
    t_all[n_tests]  = all;
    t_wr[n_tests]   = wr;
    t_addr[n_tests] = addr;
    t_data[n_tests] = data;
    t_strb[n_tests] = strb;
    n_tests++;
  endtask

  // Concurrent reads use neighbouring words and concurrent writes share one
  function automatic logic [31:0] port_addr(input int k, input int p);
    return (t_all[k] && !t_wr[k]) ? t_addr[k] + 32'(4 * p) : t_addr[k];
  endfunction

  function automatic logic [31:0] port_data(input int k, input int p);
    return t_all[k] ? t_data[k] + 32'(p) : t_data[k];
  endfunction

  task automatic derive_expected();
    logic [31:0] shadow [16];
    logic [31:0] a;
    logic [31:0] d;
    int          ptr;
    int          start;
    int          p;
    ptr = 0;  // Write arbiter starts at port 0
    for (int i = 0; i < 16; i++) shadow[i] = 32'h5a5a_0000 ^ (32'(i) * 32'h0101_0101);
    for (int k = 0; k < n_tests; k++) begin
      start = ptr;
      for (int j = 0; j < (t_all[k] ? N : 1); j++) begin
        p = !t_all[k] ? t_port[k] : (t_wr[k] ? (start + j) % N : j);
        a = port_addr(k, p);
        d = port_data(k, p);
        if (t_wr[k]) begin
          ptr = (p + 1) % N;
          t_exp_b[k][p] = (a >= 32'h40) ? axil_pkg::DECERR : axil_pkg::OKAY;
          for (int b = 0; b < 4; b++)
            if (a < 32'h40 && t_strb[k][b]) shadow[a[5:2]][8*b +: 8] = d[8*b +: 8];
        end else if (a >= 32'h40) begin
          t_exp_r[k][p] = {32'h0, axil_pkg::DECERR};
        end else begin
          t_exp_r[k][p] = {shadow[a[5:2]], axil_pkg::OKAY};
        end
      end
    end
  endtask

  task automatic run_test(input int k);
    logic [N-1:0] act;
    logic [N-1:0] pend;
    logic [N-1:0] aw_fire;
    logic [N-1:0] w_fire;
    logic [N-1:0] ar_fire;
    string        tag;
    act = '0;
    if (t_all[k]) act = '1;
    else act[t_port[k]] = 1'b1;
    for (int p = 0; p < N; p++) begin
      up_aw[p] = {port_addr(k, p), 3'b000};
      up_w[p]  = {port_data(k, p), t_strb[k]};
      up_ar[p] = {port_addr(k, p), 3'b000};
    end
    if (t_wr[k]) begin
      up_aw_valid = act;
      up_w_valid  = act;
    end else begin
      up_ar_valid = act;
    end
    pend = act;
    while (pend != '0) begin
      @(negedge clk);
      aw_fire = up_aw_valid & up_aw_ready;
      w_fire  = up_w_valid & up_w_ready;
      ar_fire = up_ar_valid & up_ar_ready;
      if (((up_aw_ready & ~up_aw_valid) | (up_w_ready & ~up_w_valid)
           | (up_ar_ready & ~up_ar_valid)) != '0)
        stop_run($sformatf("%s: ready given to a port with no request", t_name[k]));
      // Upstream acceptance is the downstream handshake passed through
      if ($countones(up_aw_ready) != int'(mst_aw_valid && mst_aw_ready)
          || $countones(up_w_ready) != int'(mst_w_valid && mst_w_ready)
          || $countones(up_ar_ready) != int'(mst_ar_valid && mst_ar_ready))
        stop_run($sformatf("%s: upstream ready does not follow the downstream handshake",
                           t_name[k]));
      for (int q = 0; q < N; q++) begin
        tag = $sformatf("%s port %0d", t_name[k], q);
        if (up_b_valid[q] && (!t_wr[k] || !pend[q]))
          stop_run($sformatf("%s: write response on a port with no write outstanding", tag));
        if (up_r_valid[q] && (t_wr[k] || !pend[q]))
          stop_run($sformatf("%s: read response on a port with no read outstanding", tag));
        if ((up_b_valid[q] && (up_aw_valid[q] || up_w_valid[q]))
            || (up_r_valid[q] && up_ar_valid[q]))
          stop_run($sformatf("%s: response before the request was accepted", tag));
        if (up_b_valid[q]) check_resp(tag, t_exp_b[k][q], up_b[q].resp);
        if (up_r_valid[q]) check_rdata(tag, t_exp_r[k][q], up_r[q]);
        if (up_b_valid[q] || up_r_valid[q]) pend[q] = 1'b0;
      end
      @(posedge clk);
      #1;
      up_aw_valid = up_aw_valid & ~aw_fire;
      up_w_valid  = up_w_valid & ~w_fire;
      up_ar_valid = up_ar_valid & ~ar_fire;
    end
  endtask

  initial begin
    rst_n       = 1'b0;
    up_aw       = '0;
    up_aw_valid = '0;
    up_w        = '0;
    up_w_valid  = '0;
    up_b_ready  = '1;
    up_ar       = '0;
    up_ar_valid = '0;
    up_r_ready  = '1;
    add_test("wr_p0", 0, 0, 1, 32'h00, 32'h0bad_f00d, 4'hf);
    add_test("rd_p0", 0, 0, 0, 32'h00, 32'h0, 4'h0);
    add_test("wr_p1", 1, 0, 1, 32'h04, 32'h1234_5678, 4'hf);
    add_test("rd_p1", 1, 0, 0, 32'h04, 32'h0, 4'h0);
    add_test("wr_p2", 2, 0, 1, 32'h08, 32'hcafe_babe, 4'hf);
    add_test("rd_p2", 2, 0, 0, 32'h08, 32'h0, 4'h0);
    add_test("wr_p3", 3, 0, 1, 32'h0c, 32'h8765_4321, 4'hf);
    add_test("rd_p3", 3, 0, 0, 32'h0c, 32'h0, 4'h0);
    add_test("wr_strb", 1, 0, 1, 32'h04, 32'hffff_ffff, 4'b0101);
    add_test("rd_strb", 1, 0, 0, 32'h04, 32'h0, 4'h0);
    add_test("wr_decerr", 2, 0, 1, 32'h44, 32'hdead_beef, 4'hf);
    add_test("rd_decerr", 0, 0, 0, 32'h44, 32'h0, 4'h0);
    add_test("rd_alias", 3, 0, 0, 32'h04, 32'h0, 4'h0);  // Word hit by 0x44
    add_test("rd_all", 0, 1, 0, 32'h00, 32'h0, 4'h0);
    add_test("wr_all", 0, 1, 1, 32'h20, 32'h5555_0000, 4'hf);
    add_test("rd_wr_all", 2, 0, 0, 32'h20, 32'h0, 4'h0);
    derive_expected();
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int k = 0; k < n_tests; k++) run_test(k);
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+verilog
verilog/axil_pkg.sv
verilog/axil_bus_if.sv
verilog/axil_rr_arbiter.sv
verilog/axil_index_fifo.sv
verilog/axil_write_mux.sv
verilog/axil_read_mux.sv
verilog/axil_mux.sv
test/axil_mem_model.sv
test/tb_axil_mux.sv
